// ==== src/gb_ctrl_macros.svh ====
/*
 * Game console download and backup control
 * Constants for download index decoding, boot ROM check,
 * palette default, cheat layout and clock-chip backup block
 */

`ifndef GB_CTRL_MACROS_SVH
`define GB_CTRL_MACROS_SVH

// Download file index values
`define GB_IDX_CART      6'h01
`define GB_IDX_PALETTE   8'd3
`define GB_IDX_CGB_BOOT  8'd4
`define GB_IDX_DMG_BOOT  8'd5
`define GB_IDX_SGB_BOOT  8'd6
`define GB_IDX_CHEAT     8'hFF
`define GB_IDX_CART_ALT  8'h80

// Byte sum of the genuine colour boot ROM
`define GB_CGB_BOOT_SUM  18'h2F3EA

// Four 24-bit palette entries, low word is padding
`define GB_PALETTE_DEFAULT 128'h828214517356305A5F1A3B4900000000

// Last word of a cheat record, completes the code
`define GB_CHEAT_LAST_OFS 4'd14

// Clock words stored in the extra backup block
`define GB_RTC_WORDS 5

`endif

// ==== src/gb_ctrl_pkg.sv ====
/*
 * Game console download and backup control
 * Shared vector types, bus structs and FSM states
 */

package gb_ctrl_pkg;

	typedef logic [15:0]  ioctl_word_t;
	typedef logic [24:0]  ioctl_addr_t;
	typedef logic [7:0]   ioctl_index_t;
	typedef logic [17:0]  boot_sum_t;
	typedef logic [31:0]  sd_lba_t;
	typedef logic [7:0]   buff_addr_t;
	typedef logic [16:0]  bk_addr_t;
	typedef logic [7:0]   ram_mask_t;

	// Four display colours, top entry first
	typedef struct packed {
		logic [23:0] pal1;
		logic [23:0] pal2;
		logic [23:0] pal3;
		logic [23:0] pal4;
		logic [31:0] pad;
	} palette_t;

	// Host download bus, one word per wr cycle
	typedef struct packed {
		logic         download;
		logic         wr;
		ioctl_index_t index;
		ioctl_addr_t  addr;
		ioctl_word_t  dout;
	} ioctl_bus_t;

	typedef struct packed {
		logic cart;
		logic palette;
		logic cgb_boot;
		logic dmg_boot;
		logic sgb_boot;
		logic boot_any;
		logic cheat;
	} dl_sel_t;

	// Cheat record, strobe on top
	typedef struct packed {
		logic        strobe;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} gg_code_t;

	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	// Block device word stream
	typedef struct packed {
		logic        ack;
		buff_addr_t  addr;
		ioctl_word_t dout;
		logic        wr;
	} sd_buff_t;

	typedef struct packed {
		bk_addr_t    addr;
		ioctl_word_t data;
		logic        wr;
		logic        rtc_wr;
	} bk_port_t;

	typedef struct packed {
		logic [31:0] timestamp;
		logic [47:0] savedtime;
		logic        inuse;
	} rtc_save_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_e;

endpackage

// ==== src/download_router.sv ====
/*
 * Download router
 * Decodes the host file index into per-target select strobes
 * and flags the start and end of a cartridge download
 */

`timescale 1ns/10ps

`include "gb_ctrl_macros.svh"

module download_router
	import gb_ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	output dl_sel_t    sel,
	output logic       cart_start,
	output logic       cart_end
);

	logic cart_prev;

	// Target select, only while a download is running
	always_comb begin
		sel = '0;
		if (ioctl.download) begin
			sel.cart     = (ioctl.index[5:0] == `GB_IDX_CART) ||
			               (ioctl.index == `GB_IDX_CART_ALT);
			sel.palette  = (ioctl.index == `GB_IDX_PALETTE);
			sel.cgb_boot = (ioctl.index == `GB_IDX_CGB_BOOT);
			sel.dmg_boot = (ioctl.index == `GB_IDX_DMG_BOOT);
			sel.sgb_boot = (ioctl.index == `GB_IDX_SGB_BOOT);
			sel.cheat    = (ioctl.index == `GB_IDX_CHEAT);
			sel.boot_any = sel.cgb_boot | sel.dmg_boot | sel.sgb_boot;
		end
	end

	// Edge pulses, one cycle after the level changes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_prev  <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			cart_prev  <= sel.cart;
			cart_start <= sel.cart & ~cart_prev;
			cart_end   <= ~sel.cart & cart_prev;
		end
	end

endmodule

// ==== src/boot_checksum.sv ====
/*
 * Boot ROM check
 * Tracks whether a custom boot ROM was loaded and sums the bytes
 * of a colour boot ROM to recognise the genuine image
 */

`timescale 1ns/10ps

`include "gb_ctrl_macros.svh"

module boot_checksum
	import gb_ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	input  dl_sel_t    sel,
	output logic       boot_gba_en,
	output logic       real_cgb_bios
);

	logic      custom_boot;
	logic      cgb_dl_prev;
	logic      cgb_first;
	boot_sum_t sum;
	boot_sum_t sum_base;
	boot_sum_t word_sum;

	assign cgb_first = sel.cgb_boot & ~cgb_dl_prev;

	// Restart from zero on the first cycle of a new image
	assign sum_base = cgb_first ? '0 : sum;
	assign word_sum = ioctl.wr ? boot_sum_t'(ioctl.dout[15:8]) + boot_sum_t'(ioctl.dout[7:0])
	                           : '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_boot <= 1'b0;
			cgb_dl_prev <= 1'b0;
			sum         <= '0;
		end else begin
			cgb_dl_prev <= sel.cgb_boot;

			// Sticky once any boot image arrives
			if (sel.boot_any)
				custom_boot <= 1'b1;

			if (sel.cgb_boot && (cgb_first || ioctl.wr))
				sum <= sum_base + word_sum;
		end
	end

	assign real_cgb_bios = (sum == `GB_CGB_BOOT_SUM);

	// Built-in ROM or the original one keeps the accelerated boot
	assign boot_gba_en = ~custom_boot | real_cgb_bios;

endmodule

// ==== src/palette_loader.sv ====
/*
 * Palette loader
 * Holds the four-entry display palette and shifts in
 * downloaded words, starting from a built-in default
 */

`timescale 1ns/10ps

`include "gb_ctrl_macros.svh"

module palette_loader
	import gb_ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	input  dl_sel_t    sel,
	output palette_t   palette
);

	// File bytes arrive little endian, entries are stored big endian
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= palette_t'(`GB_PALETTE_DEFAULT);
		end else if (sel.palette && ioctl.wr) begin
			palette <= palette_t'({palette[111:0], ioctl.dout[7:0], ioctl.dout[15:8]});
		end
	end

endmodule

// ==== src/cheat_code_loader.sv ====
/*
 * Cheat code loader
 * Assembles a cheat record from 16-bit download words and
 * issues the load strobe and the cheat list clear pulse
 */

`timescale 1ns/10ps

`include "gb_ctrl_macros.svh"

module cheat_code_loader
	import gb_ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	input  dl_sel_t    sel,
	output gg_code_t   gg_code,
	output logic       gg_clear
);

	logic        code_wr;
	logic        strobe;
	logic [31:0] flags;
	logic [31:0] address;
	logic [31:0] compare;
	logic [31:0] replace;

	assign code_wr = sel.cheat & ioctl.wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe   <= 1'b0;
			gg_clear <= 1'b0;
		end else begin
			strobe   <= code_wr && (ioctl.addr[3:0] == `GB_CHEAT_LAST_OFS);
			// New cheat file, new cartridge or palette load flushes the list
			gg_clear <= (code_wr && ioctl.addr == '0) ||
			            (sel.cart && ioctl.wr) || (sel.palette && ioctl.wr);
		end
	end

	// Record words, low half first within each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:  flags[15:0]    <= ioctl.dout;
				4'd2:  flags[31:16]   <= ioctl.dout;
				4'd4:  address[15:0]  <= ioctl.dout;
				4'd6:  address[31:16] <= ioctl.dout;
				4'd8:  compare[15:0]  <= ioctl.dout;
				4'd10: compare[31:16] <= ioctl.dout;
				4'd12: replace[15:0]  <= ioctl.dout;
				`GB_CHEAT_LAST_OFS: replace[31:16] <= ioctl.dout;
				default: ;
			endcase
		end
	end

	assign gg_code = '{strobe: strobe, flags: flags, address: address,
	                   compare: compare, replace: replace};

endmodule

// ==== src/backup_ram_ctrl.sv ====
/*
 * Backup RAM controller
 * Moves battery-backed cartridge RAM to and from the block device,
 * one 256-word block at a time, plus a clock-chip block when used
 */

`timescale 1ns/10ps

`include "gb_ctrl_macros.svh"

module backup_ram_ctrl
	import gb_ctrl_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        cart_start,
	input  logic        cart_end,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_nonzero,
	input  logic        cart_has_save,
	input  ram_mask_t   ram_mask,
	input  rtc_save_t   rtc,
	input  logic        cram_wr,
	input  logic        osd_status,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave_en,
	input  sd_buff_t    sd_buff,
	input  ioctl_word_t bk_q,
	output sd_req_t     sd_req,
	output ioctl_word_t sd_buff_din,
	output bk_port_t    bk,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        sav_pending,
	output logic        sav_supported
);

	bk_state_e state;
	sd_lba_t   lba;
	logic      sd_rd;
	logic      sd_wr;
	logic      bk_ena;
	logic      new_load;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      bk_load;
	logic      bk_save;
	logic      ack_rise;
	logic      ack_fall;
	logic      beyond_mask;
	logic      last_block;
	logic [`GB_RTC_WORDS*16-1:0] rtc_words;

	assign sav_supported = cart_has_save & bk_ena;
	assign bk_load = load_req | new_load;
	assign bk_save = save_req | (sav_pending & osd_status & autosave_en);
	assign ack_rise = sd_buff.ack & ~old_ack;
	assign ack_fall = ~sd_buff.ack & old_ack;

	// Block index past the RAM image means the clock-chip block
	assign beyond_mask = lba[8:0] > {1'b0, ram_mask};
	assign last_block = rtc.inuse ? beyond_mask : (lba[8:0] >= {1'b0, ram_mask});

	////////////////////
	// Enable and pending flags
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			new_load    <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (cart_start)
				bk_ena <= 1'b0;
			// Save image gets mounted while the cartridge streams in
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (cart_end && sav_supported)
				new_load <= 1'b1;
			else if (state == BK_XFER)
				new_load <= 1'b0;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (state == BK_XFER)
				sav_pending <= 1'b0;
		end
	end

	////////////////////
	// Block transfer FSM
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			lba        <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_buff.ack;

			// Device took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (bk_ena && ((bk_load && !old_load) || (bk_save && !old_save))) begin
						state      <= BK_XFER;
						bk_loading <= bk_load;
						lba        <= '0;
						sd_rd      <= bk_load;
						sd_wr      <= ~bk_load;
					end
					// Fresh cartridge pulls its save straight in
					if (cart_end && img_nonzero && bk_ena) begin
						state      <= BK_XFER;
						bk_loading <= 1'b1;
						lba        <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (last_block) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							lba   <= lba + 1'b1;
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	assign bk_busy = (state == BK_XFER);
	assign sd_req = '{lba: lba, rd: sd_rd, wr: sd_wr};

	////////////////////
	// Backup data routing
	assign rtc_words = {rtc.savedtime, rtc.timestamp};

	always_comb begin
		bk.addr   = {1'b0, lba[7:0], sd_buff.addr};
		bk.data   = sd_buff.dout;
		bk.wr     = ~beyond_mask & sd_buff.wr & sd_buff.ack;
		bk.rtc_wr = beyond_mask & sd_buff.wr & sd_buff.ack;

		// Timestamp words first, then saved time, rest of the block is padding
		if (!beyond_mask)
			sd_buff_din = bk_q;
		else if (sd_buff.addr < buff_addr_t'(`GB_RTC_WORDS))
			sd_buff_din = rtc_words[sd_buff.addr*16 +: 16];
		else
			sd_buff_din = 16'hFFFF;
	end

endmodule

// ==== src/gb_ctrl_top.sv ====
/*
 * Download and backup control top level
 * Connects the download router to the boot check, palette,
 * cheat and backup RAM blocks
 */

`timescale 1ns/10ps

module gb_ctrl_top
	import gb_ctrl_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  ioctl_bus_t  ioctl,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_nonzero,
	input  logic        cart_has_save,
	input  ram_mask_t   ram_mask,
	input  rtc_save_t   rtc,
	input  logic        cram_wr,
	input  logic        osd_status,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave_en,
	input  sd_buff_t    sd_buff,
	input  ioctl_word_t bk_q,
	output dl_sel_t     sel,
	output logic        cart_download,
	output logic        cart_start,
	output logic        cart_end,
	output logic        boot_gba_en,
	output logic        real_cgb_bios,
	output palette_t    palette,
	output gg_code_t    gg_code,
	output logic        gg_clear,
	output sd_req_t     sd_req,
	output ioctl_word_t sd_buff_din,
	output bk_port_t    bk,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        sav_pending,
	output logic        sav_supported
);

	assign cart_download = sel.cart;

	download_router u_router (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.sel        (sel),
		.cart_start (cart_start),
		.cart_end   (cart_end)
	);

	boot_checksum u_boot (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ioctl         (ioctl),
		.sel           (sel),
		.boot_gba_en   (boot_gba_en),
		.real_cgb_bios (real_cgb_bios)
	);

	palette_loader u_palette (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.sel     (sel),
		.palette (palette)
	);

	cheat_code_loader u_cheat (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.sel      (sel),
		.gg_code  (gg_code),
		.gg_clear (gg_clear)
	);

	backup_ram_ctrl u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (sel.cart),
		.cart_start    (cart_start),
		.cart_end      (cart_end),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_nonzero   (img_nonzero),
		.cart_has_save (cart_has_save),
		.ram_mask      (ram_mask),
		.rtc           (rtc),
		.cram_wr       (cram_wr),
		.osd_status    (osd_status),
		.load_req      (load_req),
		.save_req      (save_req),
		.autosave_en   (autosave_en),
		.sd_buff       (sd_buff),
		.bk_q          (bk_q),
		.sd_req        (sd_req),
		.sd_buff_din   (sd_buff_din),
		.bk            (bk),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.sav_pending   (sav_pending),
		.sav_supported (sav_supported)
	);

endmodule

// ==== testbench/gb_ctrl_sva.sv ====
/*
 * Protocol assertions for the download and backup control top level
 * Block device handshake, cheat strobe width and backup write ports
 */

`timescale 1ns/10ps

module gb_ctrl_sva
	import gb_ctrl_pkg::*;
(
	input logic     clk_sys,
	input logic     reset,
	input sd_req_t  sd_req,
	input sd_buff_t sd_buff,
	input gg_code_t gg_code,
	input bk_port_t bk
);

	// Number of failed assertions so far
	int fail_count = 0;

	property rd_wr_exclusive;
		@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr);
	endproperty

	// Request is withdrawn once the device has taken it
	property req_drop_after_ack;
		@(posedge clk_sys) disable iff (reset)
		$rose(sd_buff.ack) |=> (!sd_req.rd && !sd_req.wr);
	endproperty

	property strobe_single_cycle;
		@(posedge clk_sys) disable iff (reset)
		gg_code.strobe |=> !gg_code.strobe;
	endproperty

	property bk_ports_exclusive;
		@(posedge clk_sys) disable iff (reset)
		!(bk.wr && bk.rtc_wr);
	endproperty

	a_rd_wr_exclusive: assert property (rd_wr_exclusive)
		else begin
			$error("Block read and write requested together");
			fail_count++;
		end

	a_req_drop_after_ack: assert property (req_drop_after_ack)
		else begin
			$error("Block request still high one cycle after ack rose");
			fail_count++;
		end

	a_strobe_single_cycle: assert property (strobe_single_cycle)
		else begin
			$error("Cheat load strobe lasted more than one cycle");
			fail_count++;
		end

	a_bk_ports_exclusive: assert property (bk_ports_exclusive)
		else begin
			$error("Backup RAM write and clock write fired together");
			fail_count++;
		end

endmodule

// ==== testbench/tb_gb_ctrl.sv ====
/*
 * Testbench for the download and backup control top level
 * Drives host downloads and a block device model, and checks
 * boot check, palette, cheat and backup RAM behaviour
 */

`timescale 1ns/10ps

`include "gb_ctrl_macros.svh"

module tb_gb_ctrl
	import gb_ctrl_pkg::*;
();

	// Four times the longest run of 14 blocks plus the boot image
	localparam int BLOCK_CYCLES   = 256 + 8;
	localparam int TIMEOUT_CYCLES = 4 * (14 * BLOCK_CYCLES + 1200);

	logic        clk_sys = 1'b0;
	logic        reset;
	ioctl_bus_t  ioctl;
	logic        img_mounted;
	logic        img_readonly;
	logic        img_nonzero;
	logic        cart_has_save;
	ram_mask_t   ram_mask;
	rtc_save_t   rtc;
	logic        cram_wr;
	logic        osd_status;
	logic        load_req;
	logic        save_req;
	logic        autosave_en;
	sd_buff_t    sd_buff;
	ioctl_word_t bk_q;
	dl_sel_t     sel;
	logic        cart_download;
	logic        cart_start;
	logic        cart_end;
	logic        boot_gba_en;
	logic        real_cgb_bios;
	palette_t    palette;
	gg_code_t    gg_code;
	logic        gg_clear;
	sd_req_t     sd_req;
	ioctl_word_t sd_buff_din;
	bk_port_t    bk;
	logic        bk_busy;
	logic        bk_loading;
	logic        sav_pending;
	logic        sav_supported;

	logic [15:0] lfsr = 16'd75;
	int          cycle_count = 0;
	int          blocks_seen = 0;
	logic        expect_read;
	logic        dev_read;
	sd_lba_t     dev_blk;
	bk_addr_t    dev_addr;

	gb_ctrl_top dut (.*);

	bind gb_ctrl_top gb_ctrl_sva u_sva (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sd_req  (sd_req),
		.sd_buff (sd_buff),
		.gg_code (gg_code),
		.bk      (bk)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a transfer never completed", cycle_count);
			$display("Checks failed");
			$fatal(1);
		end
	end

	always @(negedge clk_sys) begin
		if (dut.u_sva.fail_count != 0) begin
			$display("A protocol assertion on the DUT failed");
			$display("Checks failed");
			$fatal(1);
		end
	end

	////////////////////
	// Helpers

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [47:0] random_bits(input int n);
		random_bits = '0;
		for (int i = 0; i < n; i++) begin
			random_bits[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endfunction

	// Backup RAM fill as a function of the whole word address
	function automatic ioctl_word_t backup_word(input bk_addr_t a);
		backup_word = a[15:0] ^ {a[7:0], a[16:9]};
	endfunction

	// Clock block layout is timestamp low/high, saved time low to high, then padding
	function automatic ioctl_word_t rtc_word(input int i);
		case (i)
			0: rtc_word = rtc.timestamp[15:0];
			1: rtc_word = rtc.timestamp[31:16];
			2: rtc_word = rtc.savedtime[15:0];
			3: rtc_word = rtc.savedtime[31:16];
			4: rtc_word = rtc.savedtime[47:32];
			default: rtc_word = 16'hFFFF;
		endcase
	endfunction

	task automatic check_value(input string test, input logic [127:0] expected,
	                           input logic [127:0] actual);
		assert (actual === expected)
		else begin
			$display("ERROR %s expected %0h actual %0h", test, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// Expected strobes run cart, palette, cgb, dmg, sgb, any boot, cheat from the top bit
	task automatic open_download(input ioctl_index_t idx, input dl_sel_t expected);
		@(posedge clk_sys);
		ioctl.download <= 1'b1;
		ioctl.index    <= idx;
		ioctl.wr       <= 1'b0;
		@(negedge clk_sys);
		check_value("download select", expected, sel);
		check_value("cart download level", expected.cart, cart_download);
	endtask

	// Returns at the falling edge after the word has been taken
	task automatic write_word(input ioctl_addr_t addr, input ioctl_word_t data);
		@(posedge clk_sys);
		ioctl.wr   <= 1'b1;
		ioctl.addr <= addr;
		ioctl.dout <= data;
		@(posedge clk_sys);
		ioctl.wr <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic close_download();
		@(posedge clk_sys);
		ioctl.download <= 1'b0;
		ioctl.index    <= '0;
		@(negedge clk_sys);
		check_value("download select idle", 7'b0, sel);
		check_value("cart download idle", 1'b0, cart_download);
	endtask

	task automatic wait_transfer();
		@(negedge clk_sys);
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	// Colour boot image of random words topped up to the genuine sum when asked
	task automatic send_boot_image(input int fill_words, input bit complete);
		int          sum;
		int          remaining;
		ioctl_addr_t addr;
		ioctl_word_t w;
		sum = 0;
		addr = '0;
		open_download(`GB_IDX_CGB_BOOT, 7'b0010010);
		for (int i = 0; i < fill_words; i++) begin
			w = ioctl_word_t'(random_bits(16));
			sum += int'(w[15:8]) + int'(w[7:0]);
			write_word(addr, w);
			addr += 2;
		end
		if (complete) begin
			remaining = `GB_CGB_BOOT_SUM - sum;
			while (remaining > 510) begin
				write_word(addr, 16'hFFFF);
				sum += 510;
				remaining -= 510;
				addr += 2;
			end
			w = {8'(remaining / 2), 8'(remaining - remaining / 2)};
			write_word(addr, w);
			sum += remaining;
		end
		close_download();
		// With a custom ROM loaded the boot mode follows the checksum alone
		check_value("boot checksum match", sum == `GB_CGB_BOOT_SUM, real_cgb_bios);
		check_value("boot mode enable", sum == `GB_CGB_BOOT_SUM, boot_gba_en);
	endtask

	////////////////////
	// Block device model
	initial begin
		sd_buff = '0;
		bk_q = '0;
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd_req.rd || sd_req.wr)) begin
				dev_read = sd_req.rd;
				dev_blk = sd_req.lba;
				check_value("block number", blocks_seen, dev_blk);
				check_value("request read", expect_read, sd_req.rd);
				check_value("request write", !expect_read, sd_req.wr);
				check_value("transfer direction", expect_read, bk_loading);
				repeat (3) @(posedge clk_sys);
				for (int i = 0; i < 256; i++) begin
					dev_addr = {1'b0, dev_blk[7:0], buff_addr_t'(i)};
					sd_buff.ack  <= 1'b1;
					sd_buff.addr <= buff_addr_t'(i);
					sd_buff.wr   <= dev_read;
					sd_buff.dout <= backup_word(dev_addr);
					bk_q         <= backup_word(dev_addr);
					@(negedge clk_sys);
					check_value("backup write", dev_read && dev_blk <= ram_mask, bk.wr);
					check_value("clock write", dev_read && dev_blk > ram_mask, bk.rtc_wr);
					check_value("backup address", dev_addr, bk.addr);
					if (dev_read) begin
						check_value("load data", backup_word(dev_addr), bk.data);
					end else if (dev_blk <= ram_mask) begin
						check_value("save data", backup_word(dev_addr), sd_buff_din);
					end else begin
						check_value("save clock data", rtc_word(i), sd_buff_din);
					end
					@(posedge clk_sys);
				end
				sd_buff <= '0;
				blocks_seen++;
			end
		end
	end

	////////////////////
	// Stimulus
	initial begin : stimulus
		ioctl_word_t cheat_words [8];
		logic [127:0] pal_model;
		ioctl_word_t  w;

		reset = 1'b1;
		ioctl = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b1;
		img_nonzero = 1'b0;
		cart_has_save = 1'b0;
		ram_mask = '0;
		rtc = '0;
		cram_wr = 1'b0;
		osd_status = 1'b0;
		load_req = 1'b0;
		save_req = 1'b0;
		autosave_en = 1'b0;
		expect_read = 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		// Boot ROM check with a genuine image then a wrong one
		check_value("boot enable after reset", 1'b1, boot_gba_en);
		send_boot_image(8, 1'b1);
		send_boot_image(6, 1'b0);

		// Palette shift register
		check_value("palette default", `GB_PALETTE_DEFAULT, palette);
		pal_model = `GB_PALETTE_DEFAULT;
		open_download(`GB_IDX_PALETTE, 7'b0100000);
		for (int i = 0; i < 6; i++) begin
			w = ioctl_word_t'(random_bits(16));
			pal_model = {pal_model[111:0], w[7:0], w[15:8]};
			write_word(ioctl_addr_t'(2 * i), w);
		end
		close_download();
		check_value("palette shift", pal_model, palette);

		// Cheat record of eight words
		open_download(`GB_IDX_CHEAT, 7'b0000001);
		for (int i = 0; i < 8; i++) begin
			cheat_words[i] = ioctl_word_t'(random_bits(16));
			write_word(ioctl_addr_t'(2 * i), cheat_words[i]);
			check_value("cheat strobe", i == 7, gg_code.strobe);
			check_value("cheat clear", i == 0, gg_clear);
		end
		close_download();
		check_value("cheat strobe end", 1'b0, gg_code.strobe);
		check_value("cheat flags", {cheat_words[1], cheat_words[0]}, gg_code.flags);
		check_value("cheat address", {cheat_words[3], cheat_words[2]}, gg_code.address);
		check_value("cheat compare", {cheat_words[5], cheat_words[4]}, gg_code.compare);
		check_value("cheat replace", {cheat_words[7], cheat_words[6]}, gg_code.replace);

		// Cartridge download with a writable save image pulls the save in
		@(posedge clk_sys);
		img_mounted   <= 1'b1;
		img_readonly  <= 1'b0;
		img_nonzero   <= 1'b1;
		cart_has_save <= 1'b1;
		ram_mask      <= 8'd3;
		blocks_seen = 0;
		expect_read = 1'b1;
		open_download(ioctl_index_t'(`GB_IDX_CART), 7'b1000000);
		check_value("cart start idle", 1'b0, cart_start);
		@(negedge clk_sys);
		check_value("cart start pulse", 1'b1, cart_start);
		@(negedge clk_sys);
		check_value("cart start width", 1'b0, cart_start);
		for (int i = 0; i < 4; i++)
			write_word(ioctl_addr_t'(2 * i), ioctl_word_t'(random_bits(16)));
		close_download();
		check_value("save supported", 1'b1, sav_supported);
		check_value("cart end idle", 1'b0, cart_end);
		@(negedge clk_sys);
		check_value("cart end pulse", 1'b1, cart_end);
		@(negedge clk_sys);
		check_value("cart end width", 1'b0, cart_end);
		wait_transfer();
		check_value("load block count", int'(ram_mask) + 1, blocks_seen);
		check_value("load busy end", 1'b0, bk_busy);

		// Manual load with the clock chip in use
		@(posedge clk_sys);
		rtc.inuse <= 1'b1;
		load_req  <= 1'b1;
		blocks_seen = 0;
		expect_read = 1'b1;
		@(posedge clk_sys);
		load_req <= 1'b0;
		wait_transfer();
		check_value("clock load block count", int'(ram_mask) + 2, blocks_seen);
		check_value("clock load busy end", 1'b0, bk_busy);

		// Autosave once the OSD opens
		@(posedge clk_sys);
		rtc.timestamp <= 32'(random_bits(32));
		rtc.savedtime <= random_bits(48);
		cram_wr       <= 1'b1;
		@(posedge clk_sys);
		cram_wr <= 1'b0;
		@(negedge clk_sys);
		check_value("save pending set", 1'b1, sav_pending);
		@(posedge clk_sys);
		autosave_en <= 1'b1;
		osd_status  <= 1'b1;
		blocks_seen = 0;
		expect_read = 1'b0;
		wait_transfer();
		check_value("save block count", int'(ram_mask) + 2, blocks_seen);
		check_value("save pending clear", 1'b0, sav_pending);
		check_value("save busy end", 1'b0, bk_busy);
		@(posedge clk_sys);
		osd_status <= 1'b0;
		repeat (4) @(posedge clk_sys);

		if (dut.u_sva.fail_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Protocol assertions failed during the run");
			$display("Checks failed");
			$fatal(1);
		end
	end

endmodule

// ==== sources.f ====
+incdir+src
src/gb_ctrl_pkg.sv
src/download_router.sv
src/boot_checksum.sv
src/palette_loader.sv
src/cheat_code_loader.sv
src/backup_ram_ctrl.sv
src/gb_ctrl_top.sv
testbench/gb_ctrl_sva.sv
testbench/tb_gb_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the download and backup control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gb_ctrl -f sources.f -o sim_gb_ctrl

./obj_dir/sim_gb_ctrl +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
exit 0
